// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing --assert
SIM_FLAGS   = --binary --timing --assert
TOP         = tb_soc_io
FILELIST    = all.f
OBJ_DIR     = obj_dir
PASS_MSG    = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
hw/soc_io_pkg.sv
hw/io_bus_port.sv
hw/ms_timer.sv
hw/spi_master.sv
hw/io_regs.sv
hw/soc_io_top.sv
sim/soc_io_checker.sv
sim/tb_soc_io.sv

// File: hw/io_bus_port.sv
// Four-phase req/ack front end producing one register access per handshake
`timescale 1ns/1ps
`default_nettype none

module io_bus_port import soc_io_pkg::*; (
    input  wire logic              clk_cpu,
    input  wire logic              rst_n,
    // CPU side
    input  wire logic              req_i,
    input  wire io_req_t           req_data_i,
    output logic                   ack_o,
    output logic [DATA_W-1:0]      rdata_o,
    // Register side
    output logic                   acc_o,
    output io_req_t                acc_req_o,
    input  wire logic [DATA_W-1:0] acc_rdata_i
);

    logic              ack_q;
    logic [DATA_W-1:0] rdata_q;

    // Fires in the cycle before ack rises, exactly once per req
    assign acc_o     = req_i && !ack_q;
    assign acc_req_o = req_data_i;         // CPU holds fields stable while req is high

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            ack_q <= 1'b0;
        end else if (acc_o) begin
            ack_q <= 1'b1;                 // Access done at this edge
        end else if (!req_i) begin
            ack_q <= 1'b0;                 // Return to idle
        end
    end

    // Read data stays put until the next access
    always_ff @(posedge clk_cpu) begin
        if (acc_o) begin
            rdata_q <= acc_rdata_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/io_regs.sv
// I/O register file: address decode, LED and SPI control registers,
// SPI start strobe and read-data multiplexer
`timescale 1ns/1ps
`default_nettype none

module io_regs import soc_io_pkg::*; (
    input  wire logic              clk_cpu,
    input  wire logic              rst_n,
    // Access from the bus port
    input  wire logic              acc_i,
    input  wire io_req_t           acc_req_i,
    output logic [DATA_W-1:0]      acc_rdata_o,
    // Timer
    input  wire logic [DATA_W-1:0] ms_count_i,
    // SPI master
    input  wire logic [DATA_W-1:0] spi_rx_i,
    input  wire logic              spi_ready_i,
    output logic                   spi_start_o,
    output logic                   spi_fast_o,
    output logic [DATA_W-1:0]      spi_tx_o,
    output logic                   spi_cs_n_o,
    // Board
    output logic [LED_W-1:0]       led_o
);

    logic             wr;
    logic [LED_W-1:0] led_q;
    logic             spi_sel_q;           // Card select, ctrl bit 0
    logic             spi_fast_q;          // Fast mode, ctrl bit 2

    assign wr = acc_i && acc_req_i.we;

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            led_q      <= '0;
            spi_sel_q  <= 1'b0;
            spi_fast_q <= 1'b0;
        end else if (wr) begin
            if (acc_req_i.addr == REG_LED) begin
                led_q <= acc_req_i.wdata[LED_W-1:0];
            end else if (acc_req_i.addr == REG_SPI_CTRL) begin
                spi_sel_q  <= acc_req_i.wdata[0];
                spi_fast_q <= acc_req_i.wdata[2];
            end
        end
    end

    // Start is sampled by the SPI master at the same edge that raises ack
    assign spi_start_o = wr && (acc_req_i.addr == REG_SPI_DATA);
    assign spi_tx_o    = acc_req_i.wdata;
    assign spi_fast_o  = spi_fast_q;
    assign spi_cs_n_o  = !spi_sel_q;       // Active-low select

    assign led_o = led_q;

    // Read mux
    always_comb begin
        case (acc_req_i.addr)
            REG_MS: begin
                acc_rdata_o = ms_count_i;
            end
            REG_LED: begin
                acc_rdata_o = '0;          // Write-only
            end
            REG_SPI_DATA: begin
                acc_rdata_o = spi_rx_i;
            end
            REG_SPI_CTRL: begin
                acc_rdata_o = {{(DATA_W - 1){1'b0}}, spi_ready_i};
            end
            REG_HW_CFG: begin
                acc_rdata_o = HW_CONFIG;
            end
            default: begin
                acc_rdata_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/ms_timer.sv
// Cycle prescaler and free-running millisecond counter
`timescale 1ns/1ps
`default_nettype none

module ms_timer import soc_io_pkg::*; (
    input  wire logic         clk_cpu,
    input  wire logic         rst_n,
    output logic [DATA_W-1:0] ms_count_o
);

    logic [PRESC_W-1:0] presc_q;
    logic [DATA_W-1:0]  ms_q;
    logic               wrap;

    assign wrap = (presc_q == PRESC_W'(TICKS_PER_MS - 1));   // Last cycle of a millisecond

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            presc_q <= '0;
            ms_q    <= '0;
        end else begin
            if (wrap) begin
                presc_q <= '0;
                ms_q    <= ms_q + 1'b1;
            end else begin
                presc_q <= presc_q + 1'b1;
            end
        end
    end

    assign ms_count_o = ms_q;

endmodule

`default_nettype wire

// File: hw/soc_io_pkg.sv
// Shared constants, register offsets and bus/pin structs for the SoC I/O block
`default_nettype none

package soc_io_pkg;

    localparam int CLK_FREQ_HZ  = 25_000_000;
    localparam int TICKS_PER_MS = CLK_FREQ_HZ / 1000;       // Cycles per millisecond
    localparam int PRESC_W      = $clog2(TICKS_PER_MS);

    localparam int DATA_W    = 32;
    localparam int IO_ADDR_W = 5;                           // Word address
    localparam int LED_W     = 8;

    // Register word offsets
    localparam logic [IO_ADDR_W-1:0] REG_MS       = 5'd0;
    localparam logic [IO_ADDR_W-1:0] REG_LED      = 5'd1;
    localparam logic [IO_ADDR_W-1:0] REG_SPI_DATA = 5'd4;
    localparam logic [IO_ADDR_W-1:0] REG_SPI_CTRL = 5'd5;
    localparam logic [IO_ADDR_W-1:0] REG_HW_CFG   = 5'd14;

    // No optional peripherals present
    localparam logic [DATA_W-1:0] HW_CONFIG = '0;

    // SPI engine
    localparam int SPI_SLOW_HALF = 4;                       // Short for simulation
    localparam int SPI_SLOW_BITS = 8;
    localparam int SPI_FAST_BITS = 32;
    localparam int SPI_HALF_W    = $clog2(SPI_SLOW_HALF);
    localparam int SPI_BIT_W     = $clog2(SPI_FAST_BITS);

    // One register access
    typedef struct packed {
        logic                 we;
        logic [IO_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]    wdata;
    } io_req_t;

    // Card-side SPI outputs
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic cs_n;
    } spi_pins_t;

endpackage

`default_nettype wire

// File: hw/soc_io_top.sv
// SoC I/O block top: bus port, registers, millisecond timer and SD-card SPI
`timescale 1ns/1ps
`default_nettype none

module soc_io_top import soc_io_pkg::*; (
    input  wire logic         clk_cpu,
    input  wire logic         rst_n,
    // CPU bus
    input  wire logic         bus_req_i,
    input  wire io_req_t      bus_req_data_i,
    output logic              bus_ack_o,
    output logic [DATA_W-1:0] bus_rdata_o,
    // Board
    output logic [LED_W-1:0]  led_o,
    // SD card
    output spi_pins_t         spi_o,
    input  wire logic         sd_do_i
);

    logic              acc;
    io_req_t           acc_req;
    logic [DATA_W-1:0] acc_rdata;
    logic [DATA_W-1:0] ms_count;
    logic [DATA_W-1:0] spi_rx;
    logic [DATA_W-1:0] spi_tx;
    logic              spi_ready;
    logic              spi_start;
    logic              spi_fast;
    logic              spi_sclk;
    logic              spi_mosi;
    logic              spi_cs_n;

    io_bus_port u_port (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .req_i       (bus_req_i),
        .req_data_i  (bus_req_data_i),
        .ack_o       (bus_ack_o),
        .rdata_o     (bus_rdata_o),
        .acc_o       (acc),
        .acc_req_o   (acc_req),
        .acc_rdata_i (acc_rdata)
    );

    io_regs u_regs (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .acc_i       (acc),
        .acc_req_i   (acc_req),
        .acc_rdata_o (acc_rdata),
        .ms_count_i  (ms_count),
        .spi_rx_i    (spi_rx),
        .spi_ready_i (spi_ready),
        .spi_start_o (spi_start),
        .spi_fast_o  (spi_fast),
        .spi_tx_o    (spi_tx),
        .spi_cs_n_o  (spi_cs_n),
        .led_o       (led_o)
    );

    ms_timer u_timer (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .ms_count_o (ms_count)
    );

    spi_master u_spi (
        .clk_cpu   (clk_cpu),
        .rst_n     (rst_n),
        .start_i   (spi_start),
        .fast_i    (spi_fast),
        .tx_data_i (spi_tx),
        .rx_data_o (spi_rx),
        .ready_o   (spi_ready),
        .sclk_o    (spi_sclk),
        .mosi_o    (spi_mosi),
        .miso_i    (sd_do_i)
    );

    assign spi_o = '{sclk: spi_sclk, mosi: spi_mosi, cs_n: spi_cs_n};

endmodule

`default_nettype wire

// File: hw/spi_master.sv
// SPI mode 0 master for the SD card
// Slow 8-bit and fast 32-bit transfers, MSB first
`timescale 1ns/1ps
`default_nettype none

module spi_master import soc_io_pkg::*; (
    input  wire logic              clk_cpu,
    input  wire logic              rst_n,
    input  wire logic              start_i,
    input  wire logic              fast_i,
    input  wire logic [DATA_W-1:0] tx_data_i,
    output logic [DATA_W-1:0]      rx_data_o,
    output logic                   ready_o,
    output logic                   sclk_o,
    output logic                   mosi_o,
    input  wire logic              miso_i
);

    logic                  ready_q;
    logic                  sclk_q;
    logic                  fast_q;
    logic [SPI_HALF_W-1:0] half_cnt;
    logic [SPI_BIT_W-1:0]  bit_cnt;
    logic [DATA_W-1:0]     tx_sh;
    logic [DATA_W-1:0]     rx_sh;
    logic                  half_end;
    logic                  last_bit;
    logic                  go;

    assign go = ready_q && start_i;        // Starts while busy are dropped

    // Fast mode toggles SCLK every cycle
    assign half_end = fast_q || (half_cnt == SPI_HALF_W'(SPI_SLOW_HALF - 1));

    assign last_bit = fast_q ? (bit_cnt == SPI_BIT_W'(SPI_FAST_BITS - 1))
                             : (bit_cnt == SPI_BIT_W'(SPI_SLOW_BITS - 1));

    // Sequencing
    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            ready_q  <= 1'b1;
            sclk_q   <= 1'b0;
            fast_q   <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
        end else if (ready_q) begin
            if (start_i) begin
                ready_q  <= 1'b0;
                fast_q   <= fast_i;
                half_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (half_end) begin
            half_cnt <= '0;
            sclk_q   <= !sclk_q;
            if (sclk_q) begin
                // Falling SCLK closes one bit
                bit_cnt <= bit_cnt + 1'b1;
                if (last_bit) begin
                    ready_q <= 1'b1;
                end
            end
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    // Shift registers
    always_ff @(posedge clk_cpu) begin
        if (go) begin
            if (fast_i) begin
                tx_sh <= tx_data_i;
            end else begin
                tx_sh <= {tx_data_i[SPI_SLOW_BITS-1:0], {(DATA_W - SPI_SLOW_BITS){1'b0}}};
            end
            rx_sh <= '0;                                // Slow result comes out zero-extended
        end else if (!ready_q && half_end) begin
            if (sclk_q) begin
                tx_sh <= {tx_sh[DATA_W-2:0], 1'b0};     // Next bit while SCLK low
            end else begin
                rx_sh <= {rx_sh[DATA_W-2:0], miso_i};   // Sample on rising SCLK
            end
        end
    end

    assign mosi_o    = tx_sh[DATA_W-1];
    assign sclk_o    = sclk_q;
    assign ready_o   = ready_q;
    assign rx_data_o = rx_sh;

endmodule

`default_nettype wire

// File: sim/soc_io_checker.sv
// Assertions on the bus handshake and the SPI idle state,
// bound into the bus port and the SPI master
`timescale 1ns/1ps
`default_nettype none

module soc_io_checker #(
    parameter bit BUS_SIDE = 1'b1          // 1: handshake rules, 0: SPI idle rules
) (
    input wire logic clk_cpu,
    input wire logic rst_n,
    input wire logic req_i,
    input wire logic ack_i,
    input wire logic ready_i,
    input wire logic sclk_i
);

    if (BUS_SIDE) begin : g_bus

        ack_rise: assert property (@(posedge clk_cpu) disable iff (rst_n)
            $rose(ack_i) |-> $past(req_i))
            else $error("ack rose without a pending request");

        ack_fall: assert property (@(posedge clk_cpu) disable iff (rst_n)
            $fell(ack_i) |-> !$past(req_i))
            else $error("ack fell while the request was still high");

    end else begin : g_spi

        // First edge out of reset
        reset_idle: assert property (@(posedge clk_cpu)
            $fell(rst_n) |-> ready_i && !sclk_i)
            else $error("SPI master not idle after reset");

        sclk_idle: assert property (@(posedge clk_cpu) disable iff (rst_n)
            ready_i |-> !sclk_i)
            else $error("SCLK high while the SPI master is ready");

    end

endmodule

bind io_bus_port soc_io_checker #(.BUS_SIDE(1'b1)) chk_port (
    .clk_cpu (clk_cpu),
    .rst_n   (rst_n),
    .req_i   (req_i),
    .ack_i   (ack_o),
    .ready_i (1'b1),                       // No SPI engine here
    .sclk_i  (1'b0)
);

bind spi_master soc_io_checker #(.BUS_SIDE(1'b0)) chk_spi (
    .clk_cpu (clk_cpu),
    .rst_n   (rst_n),
    .req_i   (1'b0),                       // No bus here
    .ack_i   (1'b0),
    .ready_i (ready_o),
    .sclk_i  (sclk_o)
);

`default_nettype wire

// File: sim/tb_soc_io.sv
// Testbench for the SoC I/O block
// Four-phase bus tasks, SD-card model, random LED, SPI and timer tests
`timescale 1ns/1ps
`default_nettype none

module tb_soc_io import soc_io_pkg::*; ();

    localparam int NUM_LED     = 8;
    localparam int NUM_XFER    = 8;        // Transfers per SPI mode
    localparam int ACC_CYCLES  = 4;        // Worst case per handshake phase
    localparam int SLOW_CYC    = SPI_SLOW_BITS * 2 * SPI_SLOW_HALF;
    localparam int FAST_CYC    = SPI_FAST_BITS * 2;
    localparam int XFER_CYCLES = (SLOW_CYC > FAST_CYC) ? SLOW_CYC : FAST_CYC;
    localparam int NUM_ACC     = 8 + 2 * NUM_LED + 4 * 2 * NUM_XFER;
    localparam int TIMEOUT_CYC = 2 * (NUM_ACC * 2 * ACC_CYCLES
                                 + 2 * NUM_XFER * (XFER_CYCLES + 2 * ACC_CYCLES)
                                 + 4 * TICKS_PER_MS) + 64;

    logic              clk_cpu = 1'b0;
    logic              rst_n;
    logic              bus_req;
    io_req_t           bus_req_data;
    logic              bus_ack;
    logic [DATA_W-1:0] bus_rdata;
    logic [LED_W-1:0]  led;
    spi_pins_t         spi;
    logic              sd_do = 1'b0;

    int                seed = 71518;
    int unsigned       cycles = 0;

    // SD-card model state
    logic [DATA_W-1:0] card_word  = '0;    // Response, sent from the top bit
    logic [DATA_W-1:0] card_rx    = '0;    // MOSI history
    int unsigned       card_falls = 0;     // Falling SCLK edges so far
    int unsigned       card_base  = 0;     // Falls at transfer start
    logic              sclk_prev  = 1'b0;

    soc_io_top dut_i (
        .clk_cpu        (clk_cpu),
        .rst_n          (rst_n),
        .bus_req_i      (bus_req),
        .bus_req_data_i (bus_req_data),
        .bus_ack_o      (bus_ack),
        .bus_rdata_o    (bus_rdata),
        .led_o          (led),
        .spi_o          (spi),
        .sd_do_i        (sd_do)
    );

    always #4 clk_cpu = !clk_cpu;          // 8 ns period

    always @(posedge clk_cpu) begin
        cycles <= cycles + 1;
    end

    // Card watches SCLK from the falling clock edge
    always @(negedge clk_cpu) begin : card_model
        int unsigned       bit_pos;
        logic [DATA_W-1:0] shifted;
        bit_pos = card_falls - card_base;
        if (spi.sclk && !sclk_prev) begin
            card_rx <= {card_rx[DATA_W-2:0], spi.mosi};   // Capture on rising SCLK
        end
        if (!spi.sclk && sclk_prev) begin
            card_falls <= card_falls + 1;
            bit_pos = bit_pos + 1;                         // Next bit after falling SCLK
        end
        sclk_prev <= spi.sclk;
        shifted = card_word << bit_pos;
        sd_do   <= shifted[DATA_W-1];
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] want,
                         input string what);
        if (got !== want) begin
            abort_run($sformatf("error at %0t ns: %s, got %h, expected %h",
                                $time, what, got, want));
        end
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (bus_ack !== level) begin
            @(negedge clk_cpu);
            n++;
            if (n > ACC_CYCLES) begin
                abort_run($sformatf("bus handshake stalled, ack never went to %b", level));
            end
        end
    endtask

    // One four-phase handshake, entered and left on a falling edge
    task automatic access(input logic we, input logic [IO_ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
        bus_req_data.we    = we;
        bus_req_data.addr  = addr;
        bus_req_data.wdata = wdata;
        bus_req            = 1'b1;
        wait_ack(1'b1);
        rdata   = bus_rdata;               // Held while ack is high
        bus_req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic write_reg(input logic [IO_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] dummy;
        access(1'b1, addr, data, dummy);
    endtask

    task automatic read_reg(input logic [IO_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        access(1'b0, addr, '0, data);
    endtask

    task automatic poll_ready();
        logic [DATA_W-1:0] st;
        int                n;
        n  = 0;
        st = '0;
        while (st[0] !== 1'b1) begin
            if (n > XFER_CYCLES) begin
                abort_run("SPI transfer never finished, ready stayed low");
            end
            read_reg(REG_SPI_CTRL, st);
            n++;
        end
        check(st, DATA_W'(1), "SPI status when idle");
    endtask

    task automatic spi_transfer(input logic fast);
        logic [DATA_W-1:0] rnd;
        logic [DATA_W-1:0] tx;
        logic [DATA_W-1:0] resp;
        logic [DATA_W-1:0] mask;
        logic [DATA_W-1:0] got;
        int unsigned       nbits;
        rnd = $random(seed);
        write_reg(REG_SPI_CTRL, {{(DATA_W - 3){1'b0}}, fast, rnd[1], rnd[0]});
        check(DATA_W'(spi.cs_n), DATA_W'(!rnd[0]), "cs_n after control write");
        nbits = fast ? SPI_FAST_BITS : SPI_SLOW_BITS;
        mask  = {DATA_W{1'b1}} >> (DATA_W - nbits);
        tx    = $random(seed);
        resp  = $random(seed);
        resp  = resp & mask;
        card_word = resp << (DATA_W - nbits);
        card_base = card_falls;
        write_reg(REG_SPI_DATA, tx);
        poll_ready();
        check(DATA_W'(card_falls - card_base), DATA_W'(nbits), "SCLK cycles in transfer");
        check(card_rx & mask, tx & mask, "bits seen on MOSI");
        read_reg(REG_SPI_DATA, got);
        check(got, resp, "received SPI word");
    endtask

    initial begin : main
        logic [DATA_W-1:0]    rnd;
        logic [DATA_W-1:0]    got;
        logic [DATA_W-1:0]    ms0;
        logic [DATA_W-1:0]    ms1;
        logic [DATA_W-1:0]    step;
        logic [IO_ADDR_W-1:0] addr;
        int unsigned          c0;
        int unsigned          span;
        int unsigned          lo;
        rst_n        = 1'b1;
        bus_req      = 1'b0;
        bus_req_data = '0;
        repeat (4) @(negedge clk_cpu);
        rst_n = 1'b0;
        @(negedge clk_cpu);

        // Idle state and constant registers
        check(DATA_W'(led), '0, "LEDs after reset");
        check(DATA_W'(spi.cs_n), DATA_W'(1), "cs_n after reset");
        check(DATA_W'(spi.sclk), '0, "SCLK after reset");
        read_reg(REG_LED, got);
        check(got, '0, "LED offset read");
        read_reg(REG_HW_CFG, got);
        check(got, '0, "configuration word");
        do begin
            rnd  = $random(seed);
            addr = rnd[IO_ADDR_W-1:0];
        end while (addr == REG_MS || addr == REG_LED || addr == REG_SPI_DATA ||
                   addr == REG_SPI_CTRL || addr == REG_HW_CFG);
        read_reg(addr, got);
        check(got, '0, $sformatf("unused offset %0d", addr));
        read_reg(REG_SPI_CTRL, got);
        check(got, DATA_W'(1), "SPI status after reset");

        for (int i = 0; i < NUM_LED; i++) begin
            rnd = $random(seed);
            write_reg(REG_LED, rnd);
            check(DATA_W'(led), DATA_W'(rnd[LED_W-1:0]), "LED outputs");
            read_reg(REG_LED, got);
            check(got, '0, "LED readback");
        end

        for (int i = 0; i < NUM_XFER; i++) begin
            spi_transfer(1'b0);
        end
        for (int i = 0; i < NUM_XFER; i++) begin
            spi_transfer(1'b1);
        end

        // Millisecond counter over about 3 ms
        c0 = cycles;
        read_reg(REG_MS, ms0);
        rnd = $random(seed);
        repeat (3 * TICKS_PER_MS + int'(rnd[9:0])) @(negedge clk_cpu);
        span = cycles - c0;
        read_reg(REG_MS, ms1);
        lo   = span / TICKS_PER_MS;
        step = ms1 - ms0;
        check(DATA_W'((step >= lo) && (step <= lo + 1)), DATA_W'(1),
              $sformatf("ms count moved by %0d over %0d cycles", step, span));

        $display("Test completed successfully");
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYC) @(posedge clk_cpu);
        abort_run($sformatf("simulation timed out after %0d cycles", TIMEOUT_CYC));
    end

endmodule

`default_nettype wire
